/* flist.f */
+incdir+rtl
+incdir+tb
rtl/csr_pkg.sv
rtl/csr_ctrl.sv
rtl/csr_decode.sv
rtl/csr_alu.sv
rtl/csr_regfile.sv
rtl/trap_unit.sv
rtl/csr_sys_top.sv
tb/tb_csr_sys.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_csr_sys -f flist.f -o sim_csr_sys \
  && ./obj_dir/sim_csr_sys | tee sim.log
grep -qx "Verification passed" sim.log && echo "Run OK" || exit 1

/* tb/csr_checks.svh */
int mismatch_count = 0;
int protocol_count = 0;

rdata_matches: assert property (
  @(posedge clk) disable iff (rst)
  wb_ack |-> (wb_rsp.rdata == exp_rsp.rdata)
) else begin
  mismatch_count++;
  $display("MISMATCH %0t: %s addr %h rdata %h, model %h", $time, cur_req.op.name(),
           cur_req.csr_addr, wb_rsp.rdata, exp_rsp.rdata);
end

illegal_matches: assert property (
  @(posedge clk) disable iff (rst)
  wb_ack |-> (wb_rsp.illegal == exp_rsp.illegal)
) else begin
  mismatch_count++;
  $display("MISMATCH %0t: %s addr %h illegal %b, model %b", $time, cur_req.op.name(),
           cur_req.csr_addr, wb_rsp.illegal, exp_rsp.illegal);
end

redirect_matches: assert property (
  @(posedge clk) disable iff (rst)
  wb_ack |-> (wb_rsp.redirect == exp_rsp.redirect) && (wb_rsp.target == exp_rsp.target)
) else begin
  mismatch_count++;
  $display("MISMATCH %0t: %s redirect %b target %h, model %b %h", $time, cur_req.op.name(),
           wb_rsp.redirect, wb_rsp.target, exp_rsp.redirect, exp_rsp.target);
end

// Capture happens on the first edge that sees stb, ack follows two edges later
ack_two_after_capture: assert property (
  @(posedge clk) disable iff (rst)
  wb_ack == ($past(wb_stb, 2) && !$past(wb_stb, 3))
) else begin
  protocol_count++;
  $display("Error at %0t: ack did not come exactly two cycles after capture", $time);
end

ack_one_cycle: assert property (
  @(posedge clk) disable iff (rst)
  wb_ack |=> !wb_ack
) else begin
  protocol_count++;
  $display("Error at %0t: ack stayed high for more than one cycle", $time);
end

ack_low_after_reset: assert property (
  @(posedge clk)
  $fell(rst) |-> !wb_ack
) else begin
  protocol_count++;
  $display("Error at %0t: ack was high right after reset", $time);
end

/* tb/tb_csr_sys.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module tb_csr_sys;

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  csr_pkg::sys_req_t wb_req;
  logic              wb_ack;
  csr_pkg::sys_rsp_t wb_rsp;

  localparam int N_RANDOM = 300;

  csr_pkg::sys_req_t reqs[$];
  csr_pkg::sys_req_t cur_req;  // Request in flight
  csr_pkg::sys_rsp_t exp_rsp;
  logic [31:0]       sh_mstatus;
  logic [31:0]       sh_mtvec;
  logic [31:0]       sh_mepc;
  logic [31:0]       sh_mcause;

  csr_sys_top csr_sys_top_i (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_req (wb_req),
    .wb_ack (wb_ack),
    .wb_rsp (wb_rsp)
  );

  `include "csr_checks.svh"

  always #50 clk = ~clk;

  function automatic logic [31:0] shadow_value(input logic [11:0] a, output logic known);
    known = 1'b1;
    case (a)
      `CSR_MSTATUS:   return sh_mstatus;
      `CSR_MTVEC:     return sh_mtvec;
      `CSR_MEPC:      return sh_mepc;
      `CSR_MCAUSE:    return sh_mcause;
      `CSR_MVENDORID: return `MVENDORID_VAL;
      `CSR_MARCHID:   return `MARCHID_VAL;
      default: begin
        known = 1'b0;
        return 32'h0;
      end
    endcase
  endfunction

  function automatic csr_pkg::sys_rsp_t predict(input csr_pkg::sys_req_t r);
    csr_pkg::sys_rsp_t p;
    logic              known;
    logic [31:0]       old;
    logic              id_write;
    p        = '0;
    old      = shadow_value(r.csr_addr, known);
    id_write = ((r.csr_addr == `CSR_MVENDORID) || (r.csr_addr == `CSR_MARCHID)) &&
               ((r.op == csr_pkg::CSRRW) || (r.operand != 32'h0));
    if (r.op == csr_pkg::ECALL) begin
      p.redirect = 1'b1;
      p.target   = sh_mtvec & ~32'h3;
    end else if (r.op == csr_pkg::MRET) begin
      p.redirect = 1'b1;
      p.target   = sh_mepc;
    end else if (!known || id_write) begin
      p.illegal = 1'b1;
    end else begin
      p.rdata = old;
    end
    return p;
  endfunction

  function automatic void update_shadow(input csr_pkg::sys_req_t r);
    logic        known;
    logic [31:0] nv;
    nv = r.operand;
    if (r.op == csr_pkg::CSRRS) nv = shadow_value(r.csr_addr, known) | r.operand;
    if (r.op == csr_pkg::CSRRC) nv = shadow_value(r.csr_addr, known) & ~r.operand;
    if (r.op == csr_pkg::ECALL) begin
      sh_mepc                   = r.pc;
      sh_mcause                 = `CAUSE_ECALL_M;
      sh_mstatus[`MSTATUS_MPIE] = sh_mstatus[`MSTATUS_MIE];
      sh_mstatus[`MSTATUS_MIE]  = 1'b0;
    end else if (r.op == csr_pkg::MRET) begin
      sh_mstatus[`MSTATUS_MIE]  = sh_mstatus[`MSTATUS_MPIE];
      sh_mstatus[`MSTATUS_MPIE] = 1'b1;
    end else if ((r.op == csr_pkg::CSRRW) || (r.operand != 32'h0)) begin
      case (r.csr_addr)
        `CSR_MSTATUS: sh_mstatus = nv;
        `CSR_MTVEC:   sh_mtvec   = nv;
        `CSR_MEPC:    sh_mepc    = nv;
        `CSR_MCAUSE:  sh_mcause  = nv;
        default: ;  // ID and unknown addresses hold
      endcase
    end
  endfunction

  function automatic void queue_req(input csr_pkg::sys_op_e op, input logic [11:0] a,
                                    input logic [31:0] operand, input logic [31:0] pc);
    csr_pkg::sys_req_t r;
    r.op       = op;
    r.csr_addr = a;
    r.operand  = operand;
    r.pc       = pc;
    reqs.push_back(r);
  endfunction

  function automatic logic [11:0] random_addr();
    case ($urandom % 8)
      0: return `CSR_MSTATUS;
      1: return `CSR_MTVEC;
      2: return `CSR_MEPC;
      3: return `CSR_MCAUSE;
      4: return `CSR_MVENDORID;
      5: return `CSR_MARCHID;
      6: return 12'h7C0;
      default: return 12'h301;
    endcase
  endfunction

  function automatic csr_pkg::sys_op_e random_op();
    case ($urandom % 10)
      0, 1, 2: return csr_pkg::CSRRW;
      3, 4, 5: return csr_pkg::CSRRS;
      6, 7:    return csr_pkg::CSRRC;
      8:       return csr_pkg::ECALL;
      default: return csr_pkg::MRET;
    endcase
  endfunction

  // Hold the request until ack, then retire it in the model
  task automatic issue(input csr_pkg::sys_req_t r);
    @(posedge clk);
    cur_req = r;
    exp_rsp = predict(r);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_req <= r;
    do begin
      @(posedge clk);
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    update_shadow(r);
  endtask

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
  endtask

  initial begin
    int seed;
    seed       = $urandom(32'h569);
    clk        = 1'b0;
    rst        = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_req     = '0;
    cur_req    = '0;
    exp_rsp    = '0;
    sh_mstatus = `CSR_RESET_VAL;
    sh_mtvec   = `CSR_RESET_VAL;
    sh_mepc    = `CSR_RESET_VAL;
    sh_mcause  = `CSR_RESET_VAL;
    queue_req(csr_pkg::CSRRS, `CSR_MSTATUS, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRS, `CSR_MTVEC, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRC, `CSR_MEPC, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRC, `CSR_MCAUSE, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRW, `CSR_MTVEC, 32'h0000_1003, 32'h0);
    queue_req(csr_pkg::CSRRS, `CSR_MSTATUS, 32'h1 << `MSTATUS_MIE, 32'h0);
    queue_req(csr_pkg::ECALL, 12'h0, 32'h0, 32'h0000_0080);
    queue_req(csr_pkg::CSRRS, `CSR_MSTATUS, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRC, `CSR_MEPC, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRS, `CSR_MCAUSE, 32'h0, 32'h0);
    queue_req(csr_pkg::MRET, 12'h0, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRS, `CSR_MSTATUS, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRS, `CSR_MVENDORID, 32'h0, 32'h0);
    queue_req(csr_pkg::CSRRW, `CSR_MARCHID, 32'h1234_5678, 32'h0);
    queue_req(csr_pkg::CSRRC, 12'h7C0, 32'h0, 32'h0);
    repeat (N_RANDOM) begin
      queue_req(random_op(), random_addr(), (($urandom % 4) == 0) ? 32'h0 : $urandom,
                $urandom & 32'hFFFF_FFFC);
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    foreach (reqs[i]) begin
      issue(reqs[i]);
    end
    repeat (4) @(posedge clk);
    print_counts();
    if ((mismatch_count + protocol_count) == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Four cycles per request plus reset and slack
  initial begin
    #1;
    repeat (reqs.size() * 4 + 50) @(posedge clk);
    $display("Timeout: the DUT did not finish %0d requests in time", reqs.size());
    print_counts();
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/csr_sys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_sys_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  csr_pkg::sys_req_t wb_req,
  output logic              wb_ack,
  output csr_pkg::sys_rsp_t wb_rsp
);

  csr_pkg::sys_req_t req_q;
  csr_pkg::sys_rsp_t rsp_next;
  csr_pkg::dec_t     dec;
  logic              commit;
  logic              do_write;
  logic [31:0]       old_val;
  logic [31:0]       new_val;
  logic [31:0]       mtvec;
  logic [31:0]       mepc;
  logic              redirect;
  logic [31:0]       target;
  logic [31:0]       trap_mepc;
  logic [31:0]       trap_cause;

  csr_ctrl csr_ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .wb_rsp   (wb_rsp),
    .req_q    (req_q),
    .commit   (commit),
    .rsp_next (rsp_next)
  );

  csr_decode csr_decode_i (.req(req_q), .dec(dec));

  csr_alu csr_alu_i (
    .op       (req_q.op),
    .operand  (req_q.operand),
    .old_val  (old_val),
    .new_val  (new_val),
    .do_write (do_write)
  );

  csr_regfile csr_regfile_i (
    .clk        (clk),
    .rst        (rst),
    .commit     (commit),
    .dec        (dec),
    .op         (req_q.op),
    .do_write   (do_write),
    .new_val    (new_val),
    .trap_mepc  (trap_mepc),
    .trap_cause (trap_cause),
    .old_val    (old_val),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  trap_unit trap_unit_i (
    .op         (req_q.op),
    .pc         (req_q.pc),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .redirect   (redirect),
    .target     (target),
    .trap_mepc  (trap_mepc),
    .trap_cause (trap_cause)
  );

  // Illegal accesses read as zero
  assign rsp_next.rdata    = dec.legal ? old_val : 32'h0;
  assign rsp_next.redirect = redirect;
  assign rsp_next.target   = target;
  assign rsp_next.illegal  = !dec.legal;

endmodule

`default_nettype wire

/* rtl/trap_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module trap_unit (
  input  csr_pkg::sys_op_e op,
  input  logic [31:0]      pc,
  input  logic [31:0]      mtvec,
  input  logic [31:0]      mepc,
  output logic             redirect,
  output logic [31:0]      target,
  output logic [31:0]      trap_mepc,
  output logic [31:0]      trap_cause
);

  logic [31:0] vec_base;

  // Direct mode only, mode bits ignored
  assign vec_base = {mtvec[31:2], 2'b00};

  always_comb begin
    case (op)
      csr_pkg::ECALL: begin
        redirect = 1'b1;
        target   = vec_base;
      end
      csr_pkg::MRET: begin
        redirect = 1'b1;
        target   = mepc;  // Back to the trapping instruction
      end
      default: begin
        redirect = 1'b0;
        target   = 32'h0;
      end
    endcase
  end

  // Only consumed by the regfile on an ECALL commit
  assign trap_mepc  = pc;
  assign trap_cause = 32'(`CAUSE_ECALL_M);

endmodule

`default_nettype wire

/* rtl/csr_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             commit,
  input  csr_pkg::dec_t    dec,
  input  csr_pkg::sys_op_e op,
  input  logic             do_write,
  input  logic [31:0]      new_val,
  input  logic [31:0]      trap_mepc,
  input  logic [31:0]      trap_cause,
  output logic [31:0]      old_val,
  output logic [31:0]      mtvec,
  output logic [31:0]      mepc
);

  logic [31:0] mstatus_q;
  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;
  logic        wr_en;

  assign wr_en = commit && dec.legal && !dec.read_only && do_write;

  always_comb begin
    case (dec.idx)
      csr_pkg::MSTATUS:   old_val = mstatus_q;
      csr_pkg::MTVEC:     old_val = mtvec_q;
      csr_pkg::MEPC:      old_val = mepc_q;
      csr_pkg::MCAUSE:    old_val = mcause_q;
      csr_pkg::MVENDORID: old_val = `MVENDORID_VAL;
      csr_pkg::MARCHID:   old_val = `MARCHID_VAL;
      default:            old_val = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= `CSR_RESET_VAL;
      mtvec_q   <= `CSR_RESET_VAL;
      mepc_q    <= `CSR_RESET_VAL;
      mcause_q  <= `CSR_RESET_VAL;
    end else begin
      if (wr_en) begin
        case (dec.idx)
          csr_pkg::MSTATUS: mstatus_q <= new_val;
          csr_pkg::MTVEC:   mtvec_q   <= new_val;
          csr_pkg::MEPC:    mepc_q    <= new_val;
          csr_pkg::MCAUSE:  mcause_q  <= new_val;
          default: ;
        endcase
      end
      if (commit && (op == csr_pkg::ECALL)) begin
        mepc_q                  <= trap_mepc;
        mcause_q                <= trap_cause;
        mstatus_q[`MSTATUS_MPIE] <= mstatus_q[`MSTATUS_MIE];
        mstatus_q[`MSTATUS_MIE]  <= 1'b0;  // Interrupts off in the handler
      end
      if (commit && (op == csr_pkg::MRET)) begin
        mstatus_q[`MSTATUS_MIE]  <= mstatus_q[`MSTATUS_MPIE];
        mstatus_q[`MSTATUS_MPIE] <= 1'b1;
      end
    end
  end

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

  // Architectural state moves only on the commit strobe from the controller
  state_needs_commit: assert property (
    @(posedge clk) disable iff (rst)
    !commit |=> $stable({mstatus_q, mtvec_q, mepc_q, mcause_q})
  );

endmodule

`default_nettype wire

/* rtl/csr_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_alu (
  input  csr_pkg::sys_op_e op,
  input  logic [31:0]      operand,
  input  logic [31:0]      old_val,
  output logic [31:0]      new_val,
  output logic             do_write
);

  logic nonzero;

  assign nonzero = (operand != 32'h0);

  always_comb begin
    case (op)
      csr_pkg::CSRRW: begin
        new_val  = operand;
        do_write = 1'b1;
      end
      csr_pkg::CSRRS: begin
        new_val  = old_val | operand;
        do_write = nonzero;
      end
      csr_pkg::CSRRC: begin
        new_val  = old_val & ~operand;
        do_write = nonzero;
      end
      default: begin  // ECALL and MRET write through the trap path
        new_val  = old_val;
        do_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/csr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_decode (
  input  csr_pkg::sys_req_t req,
  output csr_pkg::dec_t     dec
);

  csr_pkg::csr_idx_e idx;
  logic              is_trap;
  logic              write_try;

  assign is_trap = (req.op == csr_pkg::ECALL) || (req.op == csr_pkg::MRET);

  // Set and clear with rs1 == 0 only read
  assign write_try = (req.op == csr_pkg::CSRRW) ||
                     (((req.op == csr_pkg::CSRRS) || (req.op == csr_pkg::CSRRC)) &&
                      (req.operand != 32'h0));

  always_comb begin
    case (req.csr_addr)
      `CSR_MSTATUS:   idx = csr_pkg::MSTATUS;
      `CSR_MTVEC:     idx = csr_pkg::MTVEC;
      `CSR_MEPC:      idx = csr_pkg::MEPC;
      `CSR_MCAUSE:    idx = csr_pkg::MCAUSE;
      `CSR_MVENDORID: idx = csr_pkg::MVENDORID;
      `CSR_MARCHID:   idx = csr_pkg::MARCHID;
      default:        idx = csr_pkg::NONE;
    endcase
  end

  always_comb begin
    dec.read_only = (idx == csr_pkg::MVENDORID) || (idx == csr_pkg::MARCHID);
    if (is_trap) begin
      // Traps touch no CSR through the address field
      dec.idx   = csr_pkg::NONE;
      dec.legal = 1'b1;
    end else begin
      dec.idx   = idx;
      dec.legal = (idx != csr_pkg::NONE) && !(dec.read_only && write_try);
    end
  end

endmodule

`default_nettype wire

/* rtl/csr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  csr_pkg::sys_req_t  wb_req,
  output logic               wb_ack,
  output csr_pkg::sys_rsp_t  wb_rsp,
  output csr_pkg::sys_req_t  req_q,
  output logic               commit,
  input  csr_pkg::sys_rsp_t  rsp_next
);

  csr_pkg::ctrl_state_e state_q;
  logic                 commit_q;
  logic                 ack_q;
  csr_pkg::sys_rsp_t    rsp_q;
  logic                 start;

  // New transaction only accepted while idle
  assign start = (state_q == csr_pkg::IDLE) && wb_cyc && wb_stb;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= csr_pkg::IDLE;
      commit_q <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      commit_q <= start;     // One cycle after capture
      ack_q    <= commit_q;  // One cycle after commit
      case (state_q)
        csr_pkg::IDLE: begin
          if (start) begin
            state_q <= csr_pkg::EXEC;
          end
        end
        csr_pkg::EXEC: state_q <= csr_pkg::RESP;
        csr_pkg::RESP: state_q <= csr_pkg::IDLE;
        default:       state_q <= csr_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= wb_req;
    end
    if (commit_q) begin
      rsp_q <= rsp_next;  // Datapath result of the captured request
    end
  end

  assign commit = commit_q;
  assign wb_ack = ack_q;
  assign wb_rsp = rsp_q;

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack
  );

  commit_only_in_exec: assert property (
    @(posedge clk) disable iff (rst)
    commit |-> (state_q == csr_pkg::EXEC)
  );

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // System instruction sent by the execute stage
  typedef enum logic [2:0] {
    CSRRW,
    CSRRS,
    CSRRC,
    ECALL,
    MRET
  } sys_op_e;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    RESP
  } ctrl_state_e;

  typedef struct packed {
    sys_op_e     op;
    logic [11:0] csr_addr;
    logic [31:0] operand;  // rs1 value
    logic [31:0] pc;
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // Old CSR value
    logic        redirect;
    logic [31:0] target;
    logic        illegal;
  } sys_rsp_t;

  // ID registers get their own index so the read mux can pick the constant
  typedef enum logic [2:0] {
    NONE,
    MCAUSE,
    MEPC,
    MTVEC,
    MSTATUS,
    MVENDORID,
    MARCHID
  } csr_idx_e;

  typedef struct packed {
    csr_idx_e idx;
    logic     read_only;
    logic     legal;
  } dec_t;

endpackage

`default_nettype wire

/* rtl/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Machine-mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12

`define MSTATUS_MIE   3  // Global interrupt enable
`define MSTATUS_MPIE  7  // Previous MIE, saved on trap

`define CAUSE_ECALL_M 11

`define MVENDORID_VAL 32'h5253_4356
`define MARCHID_VAL   32'h0000_0017
`define CSR_RESET_VAL 32'h0000_0000

`endif
